// ==== hdl/ts_pkg.sv ====
package ts_pkg;

	// layers in walk order, LYR_IDLE when no layer is running
	typedef enum logic [2:0]
	{
		LYR_TM   = 3'd0,
		LYR_S0   = 3'd1,
		LYR_T0   = 3'd2,
		LYR_S1   = 3'd3,
		LYR_T1   = 3'd4,
		LYR_S2   = 3'd5,
		LYR_IDLE = 3'd7
	} layer_e;

	localparam int NUM_LAYERS = 6;

	// which word of a sprite record is on the read port
	typedef enum logic [1:0]
	{
		SF_R0,
		SF_R1,
		SF_R2
	} sfile_phase_e;

	// memory sizes, fixed by the address formats
	localparam int WORD_W      = 16;
	localparam int SFILE_AW    = 8;
	localparam int SFILE_WORDS = 256;
	localparam int TMB_AW      = 9;
	localparam int TMB_WORDS   = 512;

	localparam logic [7:0] SPR_LAST_ADDR     = 8'd254;
	localparam logic [8:0] TM_PREFETCH_AHEAD = 9'd16;

	typedef struct packed {
		logic s_en;
		logic t1_en;
		logic t0_en;
		logic spare;
		logic t1z_en;
		logic t0z_en;
		logic t1ys_en;
		logic t0ys_en;
	} ts_conf_t;

	typedef struct packed {
		logic [7:0] gpage;
		logic [8:0] x_offs;
		logic [8:0] y_offs;
		logic [1:0] palsel;
	} ts_planes_t;

	typedef struct packed {
		logic        yflp;
		logic        xflp;
		logic [1:0]  pal;
		logic [11:0] tnum;
	} tile_desc_t;

	typedef struct packed {
		logic       yflp;
		logic       leap;
		logic       act;
		logic       spare;
		logic [2:0] ysz;
		logic [8:0] ycrd;
	} spr_r0_t;

	typedef struct packed {
		logic       xflp;
		logic [2:0] spare;
		logic [2:0] xsz;
		logic [8:0] xcrd;
	} spr_r1_t;

	typedef struct packed {
		logic [3:0]  pal;
		logic [11:0] tnum;
	} spr_r2_t;

	// one job for the external renderer
	typedef struct packed {
		logic [5:0] addr;
		logic [8:0] line;
		logic [7:0] page;
		logic [8:0] x;
		logic [2:0] xs;
		logic       xf;
		logic [3:0] pal;
	} tsr_task_t;

endpackage

// ==== hdl/ts_sfile.sv ====
`timescale 1ns/10ps

module ts_sfile (
	input  logic                         clk,
	input  logic [ts_pkg::SFILE_AW-1:0]  waddr,
	input  logic [ts_pkg::WORD_W-1:0]    wdata,
	input  logic                         we,
	input  logic [ts_pkg::SFILE_AW-1:0]  raddr,
	output logic [ts_pkg::WORD_W-1:0]    rdata
);
	import ts_pkg::*;

	logic [WORD_W-1:0] mem [SFILE_WORDS];

	// cpu writes, scanner reads one cycle later
	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

endmodule

// ==== hdl/ts_tmbuf.sv ====
`timescale 1ns/10ps

module ts_tmbuf (
	input  logic                       clk,
	input  logic [ts_pkg::TMB_AW-1:0]  waddr,
	input  logic [ts_pkg::WORD_W-1:0]  wdata,
	input  logic                       we,
	input  logic [ts_pkg::TMB_AW-1:0]  raddr,
	output logic [ts_pkg::WORD_W-1:0]  rdata
);
	import ts_pkg::*;

	// 4 banks x 64 columns x 2 planes
	logic [WORD_W-1:0] mem [TMB_WORDS];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

endmodule

// ==== hdl/ts_layer_seq.sv ====
`timescale 1ns/10ps

module ts_layer_seq (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,
	input  logic             v_ts,
	input  logic             v_pf,
	input  ts_pkg::ts_conf_t conf,
	input  logic             tm_end,
	input  logic             t_end,
	input  logic             s_end,
	output ts_pkg::layer_e   active,
	output logic             active_valid
);
	import ts_pkg::*;

	logic [NUM_LAYERS-1:0] layer;
	logic [NUM_LAYERS-1:0] skip;
	logic [NUM_LAYERS-1:0] act_oh;
	logic [NUM_LAYERS-1:0] lyr_en;
	logic [NUM_LAYERS-1:0] lyr_ok;
	logic [NUM_LAYERS-1:0] lyr_done;
	logic [NUM_LAYERS-1:0] fin;

	always_comb
	begin
		lyr_en = {NUM_LAYERS{conf.s_en}};
		lyr_en[LYR_TM] = conf.t0_en || conf.t1_en;
		lyr_en[LYR_T0] = conf.t0_en;
		lyr_en[LYR_T1] = conf.t1_en;

		// prefetch runs in its own vertical window
		lyr_ok = {NUM_LAYERS{v_ts}};
		lyr_ok[LYR_TM] = v_pf;

		lyr_done = {NUM_LAYERS{s_end}};
		lyr_done[LYR_TM] = tm_end;
		lyr_done[LYR_T0] = t_end;
		lyr_done[LYR_T1] = t_end;
	end

	// end pulse only counts for the running layer
	assign fin = act_oh & lyr_done;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			layer <= '0;
			skip <= '1;
			act_oh <= '0;
		end
		else if (start)
		begin
			layer <= {{(NUM_LAYERS-1){1'b0}}, 1'b1};
			skip <= ~(lyr_en & lyr_ok);
			act_oh <= '0;
		end
		else
		begin
			if (|(layer & skip))
				layer <= {layer[NUM_LAYERS-2:0], 1'b0};
			skip <= skip | fin;
			// drop the layer in the cycle after its end pulse
			act_oh <= layer & ~(skip | fin);
		end
	end

	always_comb
	begin
		active = LYR_IDLE;
		for (int i = 0; i < NUM_LAYERS; i++)
			if (act_oh[i])
				active = layer_e'(3'(i));
	end

	assign active_valid = |act_oh;

endmodule

// ==== hdl/ts_tmap_prefetch.sv ====
`timescale 1ns/10ps

module ts_tmap_prefetch (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  ts_pkg::layer_e             active,
	input  logic [8:0]                 line,
	input  ts_pkg::ts_conf_t           conf,
	input  logic [7:0]                 tmpage,
	input  ts_pkg::ts_planes_t [1:0]   planes,
	input  logic                       dram_next,
	output logic [20:0]                dram_addr,
	output logic                       dram_req,
	output logic [ts_pkg::TMB_AW-1:0]  tmb_waddr,
	output logic                       tmb_we,
	output logic                       tm_end
);
	import ts_pkg::*;

	logic [4:0] tm_x;
	logic [4:0] tm_last;
	logic       at_end;
	logic       tmap;
	logic       tm_pl;
	logic [8:0] tm_line;
	logic [5:0] tm_row;

	assign tmap = active == LYR_TM;

	// bit 3 of the column counter selects the plane
	assign tm_pl = tm_x[3];
	assign tm_last = conf.t1_en ? 5'd16 : 5'd8;
	assign at_end = tm_x == tm_last;

	assign dram_req = tmap && !at_end;
	assign tmb_we = dram_req && dram_next;
	assign tm_end = tmap && at_end;

	assign tm_line = line + TM_PREFETCH_AHEAD;
	assign tm_row = tm_line[8:3] + planes[tm_pl].y_offs[8:3];

	// page, tile row, plane, burst, word in burst
	assign dram_addr = {tmpage, tm_row, tm_pl, tm_line[2:0], tm_x[2:0]};

	// bank from the tile row, then column, then plane
	assign tmb_waddr = {tm_line[4:3], tm_line[2:0], tm_x[2:0], tm_pl};

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			tm_x <= '0;
		else if (start)
			tm_x <= conf.t0_en ? 5'd0 : 5'd8;
		else if (tmb_we)
			tm_x <= tm_x + 5'd1;
	end

endmodule

// ==== hdl/ts_tile_issue.sv ====
`timescale 1ns/10ps

module ts_tile_issue (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  ts_pkg::layer_e             active,
	input  logic [8:0]                 line,
	input  ts_pkg::ts_conf_t           conf,
	input  ts_pkg::ts_planes_t [1:0]   planes,
	input  logic [5:0]                 num_tiles,
	input  ts_pkg::tile_desc_t         tmb_rdata,
	input  logic                       tsr_rdy,
	output logic [ts_pkg::TMB_AW-1:0]  tmb_raddr,
	output logic                       t_go,
	output ts_pkg::tsr_task_t          t_task,
	output logic                       t_end
);
	import ts_pkg::*;

	logic       tiles;
	logic       pl;
	logic       pl_nxt;
	logic [5:0] tx;
	logic [5:0] tx_nxt;
	ts_planes_t pc;
	ts_planes_t pn;
	logic [4:0] t_line;
	logic [4:0] tn_line;
	logic       t_act;
	logic       t_next;
	logic       t_last;

	assign tiles = active == LYR_T0 || active == LYR_T1;
	assign pc = planes[pl];
	assign pn = planes[pl_nxt];

	// line inside the four-row window, fine y offset added
	assign t_line = line[4:0] + {2'b00, pc.y_offs[2:0]};
	assign tn_line = line[4:0] + {2'b00, pn.y_offs[2:0]};

	assign t_act = (tmb_rdata.tnum != 12'd0) || (pl ? conf.t1z_en : conf.t0z_en);
	assign t_last = tx == num_tiles;
	assign t_next = tiles && (!t_act || tsr_rdy);
	assign t_go = tiles && t_act && tsr_rdy;
	assign t_end = t_next && t_last;

	always_comb
	begin
		tx_nxt = tx;
		pl_nxt = pl;
		if (start)
		begin
			tx_nxt = '0;
			pl_nxt = !conf.t0_en;
		end
		else if (t_next)
		begin
			if (t_last)
			begin
				// plane 1 follows the end of plane 0
				tx_nxt = '0;
				pl_nxt = 1'b1;
			end
			else
				tx_nxt = tx + 6'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			tx <= '0;
			pl <= 1'b0;
		end
		else
		begin
			tx <= tx_nxt;
			pl <= pl_nxt;
		end
	end

	// read ahead so the descriptor matches tx when it lands
	assign tmb_raddr = {tn_line[4:3], tx_nxt + pn.x_offs[8:3], pl_nxt};

	always_comb
	begin
		t_task.addr = tmb_rdata.tnum[5:0];
		t_task.line = {tmb_rdata.tnum[11:6], t_line[2:0] ^ {3{tmb_rdata.yflp}}};
		t_task.page = pc.gpage;
		t_task.x = {tx, 3'b000} - {6'd0, pc.x_offs[2:0]};
		t_task.xs = 3'd0;
		t_task.xf = tmb_rdata.xflp;
		t_task.pal = {pc.palsel, tmb_rdata.pal};
	end

endmodule

// ==== hdl/ts_sprite_scan.sv ====
`timescale 1ns/10ps

module ts_sprite_scan (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         start,
	input  ts_pkg::layer_e               active,
	input  logic [8:0]                   line,
	input  logic [7:0]                   sgpage,
	input  logic [ts_pkg::WORD_W-1:0]    sfile_rdata,
	input  logic                         tsr_rdy,
	output logic [ts_pkg::SFILE_AW-1:0]  sfile_raddr,
	output logic                         s_go,
	output ts_pkg::tsr_task_t            s_task,
	output logic                         s_end
);
	import ts_pkg::*;

	spr_r0_t      r0;
	spr_r1_t      r1;
	spr_r2_t      r2;
	sfile_phase_e ph;
	sfile_phase_e ph_nxt;
	logic [7:0]   s_addr;
	logic [7:0]   addr_nxt;
	logic         sprites;
	logic         done;
	logic         s_run;
	logic         show;
	logic         s_skip;
	logic         s_adv;
	logic         rec_done;
	logic         rec_last;
	logic         rec_leap;
	logic [8:0]   s_line;
	logic [5:0]   s_ymax;
	logic [5:0]   bm_off;
	logic [5:0]   bm_off_r;
	logic         leap_r;
	logic [8:0]   x_r;
	logic [2:0]   xs_r;
	logic         xf_r;

	assign r0 = sfile_rdata;
	assign r1 = sfile_rdata;
	assign r2 = sfile_rdata;

	assign sprites = active == LYR_S0 || active == LYR_S1 || active == LYR_S2;
	assign s_run = sprites && !done;

	// y test on the first record word
	assign s_line = line - r0.ycrd;
	assign s_ymax = {r0.ysz, 3'b111};
	assign show = r0.act && (s_line <= {3'b000, s_ymax});
	assign bm_off = r0.yflp ? (s_ymax - s_line[5:0]) : s_line[5:0];

	assign s_skip = s_run && ph == SF_R0 && !show;
	assign s_go = s_run && ph == SF_R2 && tsr_rdy;
	assign s_adv = s_run && ((ph == SF_R0 && show) || ph == SF_R1 || s_go);

	assign rec_done = s_skip || s_go;
	// last record ends at SPR_LAST_ADDR
	assign rec_last = rec_done && ((s_skip ? s_addr + 8'd2 : s_addr) == SPR_LAST_ADDR);
	assign rec_leap = (s_skip && r0.leap) || (s_go && leap_r);

	// once the file is done every later sprite layer ends at once
	assign s_end = (sprites && done) || rec_leap || rec_last;

	always_comb
	begin
		addr_nxt = s_addr;
		ph_nxt = ph;
		if (start)
		begin
			addr_nxt = '0;
			ph_nxt = SF_R0;
		end
		else if (rec_last)
			ph_nxt = SF_R0;
		else if (s_skip)
			addr_nxt = s_addr + 8'd3;
		else if (s_adv)
		begin
			addr_nxt = s_addr + 8'd1;
			case (ph)
				SF_R0: ph_nxt = SF_R1;
				SF_R1: ph_nxt = SF_R2;
				default: ph_nxt = SF_R0;
			endcase
		end
	end

	assign sfile_raddr = addr_nxt;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			s_addr <= '0;
			ph <= SF_R0;
			done <= 1'b0;
			leap_r <= 1'b0;
		end
		else
		begin
			s_addr <= addr_nxt;
			ph <= ph_nxt;
			if (start)
				done <= 1'b0;
			else if (rec_last)
				done <= 1'b1;
			if (s_run && ph == SF_R0 && show)
				leap_r <= r0.leap;
		end
	end

	always_ff @(posedge clk)
	begin
		if (s_run && ph == SF_R0)
			bm_off_r <= bm_off;
		if (s_run && ph == SF_R1)
		begin
			x_r <= r1.xcrd;
			xs_r <= r1.xsz;
			xf_r <= r1.xflp;
		end
	end

	always_comb
	begin
		s_task.addr = r2.tnum[5:0];
		s_task.line = {r2.tnum[11:6], 3'b000} + {3'b000, bm_off_r};
		s_task.page = sgpage;
		s_task.x = x_r;
		s_task.xs = xs_r;
		s_task.xf = xf_r;
		s_task.pal = r2.pal;
	end

endmodule

// ==== hdl/video_ts.sv ====
`timescale 1ns/10ps

module video_ts (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         start,
	input  logic [8:0]                   line,
	input  logic                         v_ts,
	input  logic                         v_pf,
	input  ts_pkg::ts_conf_t             conf,
	input  logic [7:0]                   sgpage,
	input  logic [7:0]                   tmpage,
	input  ts_pkg::ts_planes_t [1:0]     planes,
	input  logic [5:0]                   num_tiles,
	input  logic [ts_pkg::SFILE_AW-1:0]  sfile_addr,
	input  logic [ts_pkg::WORD_W-1:0]    sfile_data,
	input  logic                         sfile_we,
	output logic                         tsr_go,
	output ts_pkg::tsr_task_t            tsr_task,
	input  logic                         tsr_rdy,
	output logic [20:0]                  dram_addr,
	output logic                         dram_req,
	input  logic                         dram_next,
	input  logic [ts_pkg::WORD_W-1:0]    dram_rdata
);
	import ts_pkg::*;

	layer_e               active;
	logic                 active_valid;
	logic                 tm_end;
	logic                 t_end;
	logic                 s_end;
	logic [TMB_AW-1:0]    tmb_waddr;
	logic [TMB_AW-1:0]    tmb_raddr;
	logic                 tmb_we;
	tile_desc_t           tmb_rdata;
	logic [SFILE_AW-1:0]  sfile_raddr;
	logic [WORD_W-1:0]    sfile_rdata;
	logic                 t_go;
	logic                 s_go;
	tsr_task_t            t_task;
	tsr_task_t            s_task;
	logic                 spr_sel;

	ts_layer_seq seq_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.v_ts         (v_ts),
		.v_pf         (v_pf),
		.conf         (conf),
		.tm_end       (tm_end),
		.t_end        (t_end),
		.s_end        (s_end),
		.active       (active),
		.active_valid (active_valid)
	);

	ts_tmap_prefetch tm_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.active    (active),
		.line      (line),
		.conf      (conf),
		.tmpage    (tmpage),
		.planes    (planes),
		.dram_next (dram_next),
		.dram_addr (dram_addr),
		.dram_req  (dram_req),
		.tmb_waddr (tmb_waddr),
		.tmb_we    (tmb_we),
		.tm_end    (tm_end)
	);

	ts_tile_issue tile_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.active    (active),
		.line      (line),
		.conf      (conf),
		.planes    (planes),
		.num_tiles (num_tiles),
		.tmb_rdata (tmb_rdata),
		.tsr_rdy   (tsr_rdy),
		.tmb_raddr (tmb_raddr),
		.t_go      (t_go),
		.t_task    (t_task),
		.t_end     (t_end)
	);

	ts_sprite_scan spr_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.active      (active),
		.line        (line),
		.sgpage      (sgpage),
		.sfile_rdata (sfile_rdata),
		.tsr_rdy     (tsr_rdy),
		.sfile_raddr (sfile_raddr),
		.s_go        (s_go),
		.s_task      (s_task),
		.s_end       (s_end)
	);

	ts_sfile sfile_i (
		.clk   (clk),
		.waddr (sfile_addr),
		.wdata (sfile_data),
		.we    (sfile_we),
		.raddr (sfile_raddr),
		.rdata (sfile_rdata)
	);

	ts_tmbuf tmbuf_i (
		.clk   (clk),
		.waddr (tmb_waddr),
		.wdata (dram_rdata),
		.we    (tmb_we),
		.raddr (tmb_raddr),
		.rdata (tmb_rdata)
	);

	// renderer follows whichever unit owns the running layer
	assign spr_sel = active_valid && (active == LYR_S0 || active == LYR_S1 || active == LYR_S2);
	assign tsr_go = spr_sel ? s_go : t_go;
	assign tsr_task = spr_sel ? s_task : t_task;

endmodule

// ==== tb/video_ts_props.sv ====
`timescale 1ns/10ps

module video_ts_props (
	input logic clk,
	input logic rst_n,
	input logic tsr_go,
	input logic tsr_rdy,
	input logic dram_req,
	input logic dram_next
);

	// a task goes out only when the renderer can take it
	go_with_rdy: assert property (@(posedge clk) disable iff (!rst_n) tsr_go |-> tsr_rdy)
		else $error("tsr_go raised while tsr_rdy is low");

	idle_in_reset: assert property (@(posedge clk) !rst_n |=> (!dram_req && !tsr_go))
		else $error("dram_req or tsr_go high after a reset cycle");

	next_under_req: assert property (@(posedge clk) disable iff (!rst_n) dram_next |-> dram_req)
		else $error("dram_next pulse without dram_req");

endmodule

bind video_ts video_ts_props video_ts_props_i (.*);

// ==== tb/video_ts_tb.sv ====
`timescale 1ns/10ps

module video_ts_tb;
	import ts_pkg::*;

	localparam int TIMEOUT_CYCLES = 20000;

	logic               clk;
	logic               rst_n;
	logic               start;
	logic [8:0]         line;
	logic               v_ts;
	logic               v_pf;
	ts_conf_t           conf;
	logic [7:0]         sgpage;
	logic [7:0]         tmpage;
	ts_planes_t [1:0]   planes;
	logic [5:0]         num_tiles;
	logic [7:0]         sfile_addr;
	logic [15:0]        sfile_data;
	logic               sfile_we;
	logic               tsr_go;
	tsr_task_t          tsr_task;
	logic               tsr_rdy = 1'b1;
	logic [20:0]        dram_addr;
	logic               dram_req;
	logic               dram_next = 1'b0;
	logic [15:0]        dram_rdata = '0;

	logic [15:0]        lfsr_state = 16'd48;
	logic [15:0]        dram_mem [1024];
	logic [15:0]        sfile_ref [256];
	tile_desc_t         tmb_ref [512];
	tsr_task_t          got_q [$];
	tsr_task_t          exp_q [$];
	tsr_task_t          ord_q [$];
	logic [20:0]        dram_log [$];
	logic [20:0]        addr_q [$];
	logic               rdy_random = 1'b0;
	logic [15:0]        gap_bits;
	logic [15:0]        rdy_bits;
	logic [8:0]         pf_line;
	int                 cycles = 0;

	video_ts video_ts_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic compare_task(input string name, input tsr_task_t exp, input tsr_task_t act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s expected %h actual %h", name, exp, act));
	endtask

	task automatic compare_addr(input string name, input logic [20:0] exp,
		input logic [20:0] act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s expected %h actual %h", name, exp, act));
	endtask

	// dram answers each request word after a random gap
	always @(posedge clk)
	begin
		if (!rst_n || dram_next)
			dram_next <= 1'b0;
		else if (dram_req)
		begin
			take_bits(1, gap_bits);
			if (gap_bits[0])
			begin
				dram_next <= 1'b1;
				dram_rdata <= dram_mem[dram_addr[9:0]];
				dram_log.push_back(dram_addr);
				// bank from the prefetched line, then line in row, word, plane
				pf_line = line + 9'd16;
				tmb_ref[{pf_line[4:3], dram_addr[5:3], dram_addr[2:0], dram_addr[6]}] =
					dram_mem[dram_addr[9:0]];
			end
		end
	end

	// renderer model
	always @(posedge clk)
	begin
		if (rst_n && tsr_go)
			got_q.push_back(tsr_task);
		if (rdy_random)
		begin
			take_bits(1, rdy_bits);
			tsr_rdy <= rdy_bits[0];
		end
		else
			tsr_rdy <= 1'b1;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			abort_run("timeout: the line processing did not finish in time");
	end

	function automatic ts_conf_t make_conf(input logic s, input logic t1, input logic t0,
		input logic t1z, input logic t0z);
		ts_conf_t c;
		c = '0;
		c.s_en = s;
		c.t1_en = t1;
		c.t0_en = t0;
		c.t1z_en = t1z;
		c.t0z_en = t0z;
		return c;
	endfunction

	task automatic write_sfile(input int a, input logic [15:0] d);
		sfile_addr <= 8'(a);
		sfile_data <= d;
		sfile_we <= 1'b1;
		sfile_ref[a] = d;
		@(posedge clk);
		sfile_we <= 1'b0;
	endtask

	task automatic set_sprite(input int idx, input logic yflp, input logic leap, input logic act,
		input logic [2:0] ysz, input logic [8:0] ycrd, input logic xflp, input logic [2:0] xsz,
		input logic [8:0] xcrd, input logic [3:0] pal, input logic [11:0] tnum);
		write_sfile(idx * 3, {yflp, leap, act, 1'b0, ysz, ycrd});
		write_sfile(idx * 3 + 1, {xflp, 3'b000, xsz, xcrd});
		write_sfile(idx * 3 + 2, {pal, tnum});
	endtask

	// one start pulse and a wait until the sequencer has walked every layer
	task automatic run_line(input logic [8:0] l);
		got_q.delete();
		dram_log.delete();
		line <= l;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		while (!(video_ts_i.seq_i.layer == '0 && !video_ts_i.seq_i.active_valid))
			@(posedge clk);
		@(posedge clk);
	endtask

	// expected render tasks in layer order S0, T0, S1, T1, S2
	task automatic build_expected();
		int rec;
		int a;
		bit sdone;
		logic [8:0] sl;
		logic [5:0] ymax;
		logic [5:0] bm;
		logic [4:0] rl;
		logic [5:0] col;
		logic zen;
		logic plb;
		ts_planes_t pc;
		tile_desc_t d;
		spr_r0_t r0;
		spr_r1_t r1;
		spr_r2_t r2;
		tsr_task_t t;
		exp_q.delete();
		rec = 0;
		sdone = 0;
		for (int lyr = 1; lyr < NUM_LAYERS; lyr++)
		begin
			if (lyr % 2 == 1)
			begin
				if (conf.s_en && v_ts)
					while (!sdone)
					begin
						a = rec * 3;
						r0 = sfile_ref[a];
						r1 = sfile_ref[a + 1];
						r2 = sfile_ref[a + 2];
						sl = line - r0.ycrd;
						ymax = {r0.ysz, 3'b111};
						if (r0.act && sl <= {3'b000, ymax})
						begin
							bm = r0.yflp ? ymax - sl[5:0] : sl[5:0];
							t.addr = r2.tnum[5:0];
							t.line = {r2.tnum[11:6], 3'b000} + {3'b000, bm};
							t.page = sgpage;
							t.x = r1.xcrd;
							t.xs = r1.xsz;
							t.xf = r1.xflp;
							t.pal = r2.pal;
							exp_q.push_back(t);
						end
						rec++;
						if (a + 2 >= 254)
							sdone = 1;
						if (r0.leap)
							break;
					end
			end
			else
			begin
				plb = (lyr == 4);
				if (v_ts && (plb ? conf.t1_en : conf.t0_en))
				begin
					pc = planes[plb];
					zen = plb ? conf.t1z_en : conf.t0z_en;
					rl = line[4:0] + {2'b00, pc.y_offs[2:0]};
					for (int tx = 0; tx <= num_tiles; tx++)
					begin
						col = 6'(tx) + pc.x_offs[8:3];
						d = tmb_ref[{rl[4:3], col, plb}];
						if (d.tnum != 12'd0 || zen)
						begin
							t.addr = d.tnum[5:0];
							t.line = {d.tnum[11:6], rl[2:0] ^ {3{d.yflp}}};
							t.page = pc.gpage;
							t.x = 9'(tx * 8) - {6'd0, pc.x_offs[2:0]};
							t.xs = 3'd0;
							t.xf = d.xflp;
							t.pal = {pc.palsel, d.pal};
							exp_q.push_back(t);
						end
					end
				end
			end
		end
	endtask

	task automatic check_tasks(input string name);
		build_expected();
		if (got_q.size() != exp_q.size())
			abort_run($sformatf("%s: renderer got %0d tasks where %0d were expected",
				name, got_q.size(), exp_q.size()));
		foreach (exp_q[i])
			compare_task(name, exp_q[i], got_q[i]);
	endtask

	task automatic check_addrs(input string name);
		logic [8:0] pfl;
		logic [5:0] row;
		addr_q.delete();
		pfl = line + 9'd16;
		for (int p = 0; p < 2; p++)
			if (v_pf && (p == 0 ? conf.t0_en : conf.t1_en))
				for (int c = 0; c < 8; c++)
				begin
					row = pfl[8:3] + planes[p].y_offs[8:3];
					addr_q.push_back({tmpage, row, 1'(p), pfl[2:0], 3'(c)});
				end
		if (dram_log.size() != addr_q.size())
			abort_run($sformatf("%s: dram saw %0d words where %0d were expected",
				name, dram_log.size(), addr_q.size()));
		foreach (addr_q[i])
			compare_addr(name, addr_q[i], dram_log[i]);
	endtask

	task automatic prefetch_rows();
		v_pf <= 1'b1;
		v_ts <= 1'b0;
		conf <= make_conf(0, 0, 1, 0, 0);
		run_line(9'd24);
		check_addrs("prefetch t0");
		conf <= make_conf(0, 1, 1, 0, 0);
		// lines 24..31 fill bank 1 of both planes
		for (int l = 24; l < 32; l++)
		begin
			run_line(9'(l));
			check_addrs("prefetch t0 t1");
		end
		v_pf <= 1'b0;
		run_line(9'd30);
		check_addrs("prefetch v_pf low");
	endtask

	task automatic tile_tasks();
		v_pf <= 1'b0;
		v_ts <= 1'b1;
		conf <= make_conf(0, 1, 1, 0, 0);
		run_line(9'd40);
		check_tasks("tiles");
		conf <= make_conf(0, 1, 1, 1, 1);
		run_line(9'd40);
		check_tasks("tiles zero enable");
	endtask

	task automatic sprite_tasks();
		set_sprite(0, 0, 0, 1, 3'd1, 9'd96, 0, 3'd1, 9'd50, 4'd5, 12'h3a1);
		set_sprite(1, 0, 0, 1, 3'd3, 9'd200, 0, 3'd0, 9'd8, 4'd1, 12'h011);
		set_sprite(2, 0, 0, 0, 3'd1, 9'd100, 0, 3'd0, 9'd9, 4'd2, 12'h022);
		set_sprite(3, 1, 0, 1, 3'd2, 9'd90, 1, 3'd2, 9'd400, 4'd9, 12'h7ff);
		set_sprite(4, 0, 0, 1, 3'd7, 9'd0, 0, 3'd3, 9'd70, 4'd4, 12'h044);
		set_sprite(5, 0, 0, 1, 3'd0, 9'd98, 0, 3'd0, 9'd0, 4'd15, 12'hc55);
		v_pf <= 1'b0;
		v_ts <= 1'b1;
		conf <= make_conf(1, 0, 0, 0, 0);
		run_line(9'd100);
		check_tasks("sprites");
	endtask

	task automatic layer_order();
		// leap bits split the records over S0, S1 and S2
		set_sprite(0, 0, 1, 1, 3'd0, 9'd36, 0, 3'd0, 9'd10, 4'd3, 12'h0c5);
		set_sprite(1, 1, 0, 1, 3'd1, 9'd38, 1, 3'd1, 9'd100, 4'd6, 12'h2b3);
		set_sprite(2, 0, 1, 0, 3'd0, 9'd40, 0, 3'd0, 9'd0, 4'd0, 12'h000);
		set_sprite(3, 0, 0, 1, 3'd0, 9'd40, 0, 3'd4, 9'd300, 4'd12, 12'h9e1);
		set_sprite(4, 0, 0, 0, 3'd0, 9'd0, 0, 3'd0, 9'd0, 4'd0, 12'h000);
		set_sprite(5, 0, 0, 0, 3'd0, 9'd0, 0, 3'd0, 9'd0, 4'd0, 12'h000);
		v_pf <= 1'b0;
		v_ts <= 1'b1;
		conf <= make_conf(1, 1, 1, 0, 0);
		run_line(9'd40);
		check_tasks("layer order");
		ord_q = exp_q;
		conf <= make_conf(0, 1, 0, 0, 0);
		run_line(9'd40);
		check_tasks("t1 only");
		v_ts <= 1'b0;
		conf <= make_conf(1, 1, 1, 0, 0);
		run_line(9'd40);
		check_tasks("v_ts low");
	endtask

	task automatic random_ready();
		v_pf <= 1'b0;
		v_ts <= 1'b1;
		conf <= make_conf(1, 1, 1, 0, 0);
		rdy_random <= 1'b1;
		run_line(9'd40);
		rdy_random <= 1'b0;
		if (got_q.size() != ord_q.size())
			abort_run($sformatf("back-pressure: %0d tasks where %0d were expected",
				got_q.size(), ord_q.size()));
		foreach (ord_q[i])
			compare_task("back-pressure", ord_q[i], got_q[i]);
	endtask

	initial
	begin
		logic [15:0] d;
		logic [15:0] z;
		rst_n = 1'b0;
		start = 1'b0;
		line = '0;
		v_ts = 1'b0;
		v_pf = 1'b0;
		conf = '0;
		sgpage = 8'h77;
		tmpage = 8'h3c;
		planes[0] = '{gpage: 8'h21, x_offs: 9'd19, y_offs: 9'd3, palsel: 2'd1};
		planes[1] = '{gpage: 8'h5a, x_offs: 9'd477, y_offs: 9'd21, palsel: 2'd2};
		num_tiles = 6'd9;
		sfile_addr = '0;
		sfile_data = '0;
		sfile_we = 1'b0;
		// about one word in four is an empty tile
		for (int i = 0; i < 1024; i++)
		begin
			take_bits(16, d);
			take_bits(2, z);
			if (z[1:0] == 2'b00)
				d[11:0] = '0;
			dram_mem[i] = d;
		end
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		for (int a = 0; a < 256; a++)
			write_sfile(a, 16'h0000);
		prefetch_rows();
		tile_tasks();
		sprite_tasks();
		layer_order();
		random_ready();
		$display("test passed");
		$finish;
	end

endmodule

// ==== verilog.f ====
hdl/ts_pkg.sv
hdl/ts_sfile.sv
hdl/ts_tmbuf.sv
hdl/ts_layer_seq.sv
hdl/ts_tmap_prefetch.sv
hdl/ts_tile_issue.sv
hdl/ts_sprite_scan.sv
hdl/video_ts.sv
tb/video_ts_props.sv
tb/video_ts_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module video_ts_tb -f verilog.f -o video_ts_sim
	./obj_dir/video_ts_sim | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
